//--- rtl/dma_reg_pkg.sv
package dma_reg_pkg;

    // Register bus widths
    localparam int AXIL_ADDR_WIDTH = 4;
    localparam int AXIL_DATA_WIDTH = 32;
    localparam int AXIL_STRB_WIDTH = AXIL_DATA_WIDTH / 8;

    // Register offsets
    localparam logic [AXIL_ADDR_WIDTH-1:0] REG_CTRL   = 4'h0;
    localparam logic [AXIL_ADDR_WIDTH-1:0] REG_BASE   = 4'h4;
    localparam logic [AXIL_ADDR_WIDTH-1:0] REG_STATUS = 4'h8;
    localparam logic [AXIL_ADDR_WIDTH-1:0] REG_COUNT  = 4'hC;

    // CTRL bits; arm is self-clearing and reads back as 0
    localparam int CTRL_ARM_BIT = 0;

    // STATUS bits
    localparam int STATUS_DONE_BIT = 0;
    localparam int STATUS_BUSY_BIT = 1;

    // Response code, the block only ever answers OKAY
    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

//--- rtl/dma_data_pkg.sv
package dma_data_pkg;

    // One incoming sample
    localparam int SAMPLE_DATA_WIDTH = 32;
    localparam int SAMPLE_DEST_WIDTH = 12;

    typedef struct packed {
        logic [SAMPLE_DATA_WIDTH-1:0] data;
        logic [SAMPLE_DEST_WIDTH-1:0] dest;
    } sample_t;

    // A beat holds two halves, each a data word followed by a zero-extended dest word
    localparam int WORD_WIDTH = 32;

    typedef struct packed {
        logic [WORD_WIDTH-1:0] dest;
        logic [WORD_WIDTH-1:0] data;
    } beat_half_t;

    localparam int HALF_WIDTH = $bits(beat_half_t);

    // Beat geometry on the memory bus
    localparam int BEAT_WIDTH = 2 * HALF_WIDTH;
    localparam int BEAT_BYTES = BEAT_WIDTH / 8;
    localparam logic [2:0] BEAT_SIZE = 3'($clog2(BEAT_BYTES));

endpackage

//--- rtl/beat_if.sv
`timescale 1ns/1ps

interface beat_if;
    import dma_data_pkg::*;

    // Packed beat, with its low half in the least significant bits
    logic [BEAT_WIDTH-1:0] data;
    // Marks the beat that carries the stream's final sample
    logic                  last;
    logic                  valid;
    logic                  ready;

    modport source (
        output data,
        output last,
        output valid,
        input  ready
    );

    modport sink (
        input  data,
        input  last,
        input  valid,
        output ready
    );

endinterface

//--- rtl/dma_regs.sv
`timescale 1ns/1ps

module dma_regs #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                                   axi_out,
    input  logic                                   rst,
    input  logic [dma_reg_pkg::AXIL_ADDR_WIDTH-1:0] s_axil_awaddr,
    input  logic                                   s_axil_awvalid,
    input  logic [dma_reg_pkg::AXIL_DATA_WIDTH-1:0] s_axil_wdata,
    input  logic [dma_reg_pkg::AXIL_STRB_WIDTH-1:0] s_axil_wstrb,
    input  logic                                   s_axil_wvalid,
    output logic                                   s_axil_awready,
    output logic                                   s_axil_wready,
    output logic [1:0]                             s_axil_bresp,
    output logic                                   s_axil_bvalid,
    input  logic                                   s_axil_bready,
    input  logic [dma_reg_pkg::AXIL_ADDR_WIDTH-1:0] s_axil_araddr,
    input  logic                                   s_axil_arvalid,
    input  logic                                   s_axil_rready,
    output logic                                   s_axil_arready,
    output logic [dma_reg_pkg::AXIL_DATA_WIDTH-1:0] s_axil_rdata,
    output logic [1:0]                             s_axil_rresp,
    output logic                                   s_axil_rvalid,
    output logic                                   arm,
    output logic [ADDR_WIDTH-1:0]                  base_addr,
    input  logic [dma_reg_pkg::AXIL_DATA_WIDTH-1:0] beats_done,
    input  logic                                   done
);
    import dma_reg_pkg::*;

    logic [AXIL_DATA_WIDTH-1:0] base_q;
    logic [AXIL_DATA_WIDTH-1:0] rd_word;
    logic                       armed_q;
    logic                       busy;
    logic                       wr_hs;
    logic                       rd_hs;

    // AW and W are taken together, and only when no response is pending
    assign s_axil_awready = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
    assign s_axil_wready  = s_axil_awready;
    assign s_axil_arready = !s_axil_rvalid;
    assign s_axil_bresp   = RESP_OKAY;
    assign s_axil_rresp   = RESP_OKAY;

    assign wr_hs = s_axil_awvalid && s_axil_awready;
    assign rd_hs = s_axil_arvalid && s_axil_arready;

    assign base_addr = base_q[ADDR_WIDTH-1:0];
    // Busy from the first arm until the write master reports done
    assign busy      = armed_q && !done;

    always_ff @(posedge axi_out) begin
        if (rst) begin
            s_axil_bvalid <= 1'b0;
            arm           <= 1'b0;
            armed_q       <= 1'b0;
            base_q        <= '0;
        end else begin
            arm <= 1'b0;
            if (arm) begin
                armed_q <= 1'b1;
            end
            if (s_axil_bvalid && s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end
            if (wr_hs) begin
                s_axil_bvalid <= 1'b1;
                case (s_axil_awaddr)
                    REG_CTRL: arm <= s_axil_wstrb[0] && s_axil_wdata[CTRL_ARM_BIT];
                    REG_BASE: begin
                        for (int i = 0; i < AXIL_STRB_WIDTH; i++) begin
                            if (s_axil_wstrb[i]) begin
                                base_q[8*i +: 8] <= s_axil_wdata[8*i +: 8];
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // CTRL and unmapped offsets read as zero
    always_comb begin
        rd_word = '0;
        case (s_axil_araddr)
            REG_BASE:   rd_word = base_q;
            REG_COUNT:  rd_word = beats_done;
            REG_STATUS: begin
                rd_word[STATUS_DONE_BIT] = done;
                rd_word[STATUS_BUSY_BIT] = busy;
            end
            default:    rd_word = '0;
        endcase
    end

    always_ff @(posedge axi_out) begin
        if (rst) begin
            s_axil_rvalid <= 1'b0;
        end else if (rd_hs) begin
            s_axil_rvalid <= 1'b1;
        end else if (s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge axi_out) begin
        if (rd_hs) begin
            s_axil_rdata <= rd_word;
        end
    end

    a_bvalid_hold: assert property (@(posedge axi_out) disable iff (rst)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid);

    a_arm_pulse: assert property (@(posedge axi_out) disable iff (rst)
        arm |=> !arm);

endmodule

//--- rtl/sample_packer.sv
`timescale 1ns/1ps

module sample_packer #(
    parameter int DEST_WIDTH = 12
) (
    input  logic                                      axi_out,
    input  logic                                      rst,
    input  logic                                      arm,
    input  logic [dma_data_pkg::SAMPLE_DATA_WIDTH-1:0] s_tdata,
    input  logic [DEST_WIDTH-1:0]                     s_tdest,
    input  logic                                      s_tlast,
    input  logic                                      s_tvalid,
    output logic                                      s_tready,
    beat_if.source                                    beats
);
    import dma_data_pkg::*;

    beat_half_t in_half;
    beat_half_t held_q;
    logic       half_full_q;
    logic       open_q;
    logic       accept;
    logic       load_beat;

    assign in_half.data = WORD_WIDTH'(s_tdata);
    assign in_half.dest = WORD_WIDTH'(s_tdest);

    // Stall the stream while a finished beat has not been taken yet
    assign s_tready  = open_q && (!beats.valid || beats.ready);
    assign accept    = s_tvalid && s_tready;
    assign load_beat = accept && (half_full_q || s_tlast);

    always_ff @(posedge axi_out) begin
        if (rst) begin
            open_q      <= 1'b0;
            half_full_q <= 1'b0;
            beats.valid <= 1'b0;
            beats.last  <= 1'b0;
        end else begin
            if (beats.valid && beats.ready) begin
                beats.valid <= 1'b0;
            end
            if (arm) begin
                open_q      <= 1'b1;
                half_full_q <= 1'b0;
            end else if (accept) begin
                half_full_q <= !load_beat;
                if (load_beat) begin
                    beats.valid <= 1'b1;
                    beats.last  <= s_tlast;
                end
                // The input closes once the last sample is in
                if (s_tlast) begin
                    open_q <= 1'b0;
                end
            end
        end
    end

    // A lone final sample goes into the low half with zeros above it
    always_ff @(posedge axi_out) begin
        if (accept && !load_beat) begin
            held_q <= in_half;
        end
        if (load_beat) begin
            beats.data <= half_full_q ? {in_half, held_q} : {{HALF_WIDTH{1'b0}}, in_half};
        end
    end

    a_beat_stable: assert property (@(posedge axi_out) disable iff (rst)
        beats.valid && !beats.ready |=> beats.valid && $stable(beats.data));

endmodule

//--- rtl/axi_write_master.sv
`timescale 1ns/1ps

module axi_write_master #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                                    axi_out,
    input  logic                                    rst,
    input  logic                                    arm,
    input  logic [ADDR_WIDTH-1:0]                   base_addr,
    beat_if.sink                                    beats,
    output logic [ADDR_WIDTH-1:0]                   m_axi_awaddr,
    output logic [7:0]                              m_axi_awlen,
    output logic [2:0]                              m_axi_awsize,
    output logic                                    m_axi_awvalid,
    input  logic                                    m_axi_awready,
    output logic [dma_data_pkg::BEAT_WIDTH-1:0]     m_axi_wdata,
    output logic [dma_data_pkg::BEAT_BYTES-1:0]     m_axi_wstrb,
    output logic                                    m_axi_wlast,
    output logic                                    m_axi_wvalid,
    input  logic                                    m_axi_wready,
    input  logic [1:0]                              m_axi_bresp,
    input  logic                                    m_axi_bvalid,
    output logic                                    m_axi_bready,
    output logic [dma_reg_pkg::AXIL_DATA_WIDTH-1:0] beats_done,
    output logic                                    done
);
    import dma_data_pkg::*;
    import dma_reg_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT
    } state_t;

    state_t                state_q;
    logic [ADDR_WIDTH-1:0] wr_ptr_q;
    logic                  last_q;
    logic                  aw_sent_q;
    logic                  w_sent_q;
    logic                  aw_done;
    logic                  w_done;
    logic                  take_beat;

    // Single-beat writes of a full beat
    assign m_axi_awlen  = 8'd0;
    assign m_axi_awsize = BEAT_SIZE;
    assign m_axi_wstrb  = '1;
    assign m_axi_wlast  = 1'b1;

    assign beats.ready   = (state_q == S_IDLE);
    assign take_beat     = beats.valid && beats.ready;
    assign m_axi_awvalid = (state_q == S_ISSUE) && !aw_sent_q;
    assign m_axi_wvalid  = (state_q == S_ISSUE) && !w_sent_q;
    assign m_axi_bready  = (state_q == S_WAIT);

    assign aw_done = aw_sent_q || m_axi_awready;
    assign w_done  = w_sent_q || m_axi_wready;

    always_ff @(posedge axi_out) begin
        if (rst) begin
            state_q    <= S_IDLE;
            aw_sent_q  <= 1'b0;
            w_sent_q   <= 1'b0;
            beats_done <= '0;
            done       <= 1'b0;
        end else begin
            if (arm) begin
                beats_done <= '0;
                done       <= 1'b0;
            end
            case (state_q)
                S_IDLE: begin
                    if (take_beat) begin
                        state_q <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    // Both channels must finish before the response is awaited
                    if (aw_done && w_done) begin
                        state_q   <= S_WAIT;
                        aw_sent_q <= 1'b0;
                        w_sent_q  <= 1'b0;
                    end else begin
                        aw_sent_q <= aw_done;
                        w_sent_q  <= w_done;
                    end
                end
                S_WAIT: begin
                    if (m_axi_bvalid) begin
                        state_q    <= S_IDLE;
                        beats_done <= beats_done + 1'b1;
                        done       <= last_q;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Address pointer and the captured beat
    always_ff @(posedge axi_out) begin
        if (arm) begin
            wr_ptr_q <= base_addr;
        end else if (take_beat) begin
            wr_ptr_q <= wr_ptr_q + ADDR_WIDTH'(BEAT_BYTES);
        end
        if (take_beat) begin
            m_axi_awaddr <= wr_ptr_q;
            m_axi_wdata  <= beats.data;
            last_q       <= beats.last;
        end
    end

    a_awvalid_hold: assert property (@(posedge axi_out) disable iff (rst)
        m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid);

    // Responses are counted without inspection, so the memory must answer OKAY
    a_bresp_okay: assert property (@(posedge axi_out) disable iff (rst)
        m_axi_bvalid && m_axi_bready |-> m_axi_bresp == RESP_OKAY);

endmodule

//--- rtl/stream_dma.sv
`timescale 1ns/1ps

module stream_dma #(
    parameter int ADDR_WIDTH = 32,
    parameter int DEST_WIDTH = 12
) (
    input  logic                                      axi_out,
    input  logic                                      rst,
    input  logic [dma_reg_pkg::AXIL_ADDR_WIDTH-1:0]   s_axil_awaddr,
    input  logic                                      s_axil_awvalid,
    output logic                                      s_axil_awready,
    input  logic [dma_reg_pkg::AXIL_DATA_WIDTH-1:0]   s_axil_wdata,
    input  logic [dma_reg_pkg::AXIL_STRB_WIDTH-1:0]   s_axil_wstrb,
    input  logic                                      s_axil_wvalid,
    output logic                                      s_axil_wready,
    output logic [1:0]                                s_axil_bresp,
    output logic                                      s_axil_bvalid,
    input  logic                                      s_axil_bready,
    input  logic [dma_reg_pkg::AXIL_ADDR_WIDTH-1:0]   s_axil_araddr,
    input  logic                                      s_axil_arvalid,
    output logic                                      s_axil_arready,
    output logic [dma_reg_pkg::AXIL_DATA_WIDTH-1:0]   s_axil_rdata,
    output logic [1:0]                                s_axil_rresp,
    output logic                                      s_axil_rvalid,
    input  logic                                      s_axil_rready,
    input  logic [dma_data_pkg::SAMPLE_DATA_WIDTH-1:0] s_tdata,
    input  logic [DEST_WIDTH-1:0]                     s_tdest,
    input  logic                                      s_tlast,
    input  logic                                      s_tvalid,
    output logic                                      s_tready,
    output logic [ADDR_WIDTH-1:0]                     m_axi_awaddr,
    output logic [7:0]                                m_axi_awlen,
    output logic [2:0]                                m_axi_awsize,
    output logic                                      m_axi_awvalid,
    input  logic                                      m_axi_awready,
    output logic [dma_data_pkg::BEAT_WIDTH-1:0]       m_axi_wdata,
    output logic [dma_data_pkg::BEAT_BYTES-1:0]       m_axi_wstrb,
    output logic                                      m_axi_wlast,
    output logic                                      m_axi_wvalid,
    input  logic                                      m_axi_wready,
    input  logic [1:0]                                m_axi_bresp,
    input  logic                                      m_axi_bvalid,
    output logic                                      m_axi_bready
);
    import dma_reg_pkg::*;

    logic                       arm;
    logic [ADDR_WIDTH-1:0]      base_addr;
    logic [AXIL_DATA_WIDTH-1:0] beats_done;
    logic                       done;

    beat_if beats ();

    dma_regs #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_dma_regs (
        .axi_out(axi_out), .rst(rst),
        .s_axil_awaddr(s_axil_awaddr), .s_axil_awvalid(s_axil_awvalid),
        .s_axil_wdata(s_axil_wdata), .s_axil_wstrb(s_axil_wstrb),
        .s_axil_wvalid(s_axil_wvalid), .s_axil_awready(s_axil_awready),
        .s_axil_wready(s_axil_wready), .s_axil_bresp(s_axil_bresp),
        .s_axil_bvalid(s_axil_bvalid), .s_axil_bready(s_axil_bready),
        .s_axil_araddr(s_axil_araddr), .s_axil_arvalid(s_axil_arvalid),
        .s_axil_rready(s_axil_rready), .s_axil_arready(s_axil_arready),
        .s_axil_rdata(s_axil_rdata), .s_axil_rresp(s_axil_rresp),
        .s_axil_rvalid(s_axil_rvalid),
        .arm(arm), .base_addr(base_addr), .beats_done(beats_done), .done(done)
    );

    sample_packer #(
        .DEST_WIDTH(DEST_WIDTH)
    ) u_sample_packer (
        .axi_out(axi_out), .rst(rst), .arm(arm),
        .s_tdata(s_tdata), .s_tdest(s_tdest), .s_tlast(s_tlast),
        .s_tvalid(s_tvalid), .s_tready(s_tready),
        .beats(beats.source)
    );

    axi_write_master #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_axi_write_master (
        .axi_out(axi_out), .rst(rst), .arm(arm), .base_addr(base_addr),
        .beats(beats.sink),
        .m_axi_awaddr(m_axi_awaddr), .m_axi_awlen(m_axi_awlen),
        .m_axi_awsize(m_axi_awsize), .m_axi_awvalid(m_axi_awvalid),
        .m_axi_awready(m_axi_awready),
        .m_axi_wdata(m_axi_wdata), .m_axi_wstrb(m_axi_wstrb),
        .m_axi_wlast(m_axi_wlast), .m_axi_wvalid(m_axi_wvalid),
        .m_axi_wready(m_axi_wready),
        .m_axi_bresp(m_axi_bresp), .m_axi_bvalid(m_axi_bvalid),
        .m_axi_bready(m_axi_bready),
        .beats_done(beats_done), .done(done)
    );

endmodule

//--- verification/stream_dma_tb.sv
`timescale 1ns/1ps

module stream_dma_tb;
    import dma_reg_pkg::*;
    import dma_data_pkg::*;

    localparam int ADDR_WIDTH = 32;
    localparam int DEST_WIDTH = 12;
    localparam int NUM_ROWS   = 4;

    // Each row is one transfer: base address and number of samples
    localparam logic [31:0] ROW_BASE [NUM_ROWS] = '{32'h1000, 32'h2040, 32'h3000, 32'h4000};
    localparam int          ROW_COUNT [NUM_ROWS] = '{8, 7, 1, 32};

    logic                         axi_out;
    logic                         rst;
    logic [AXIL_ADDR_WIDTH-1:0]   s_axil_awaddr;
    logic                         s_axil_awvalid;
    logic                         s_axil_awready;
    logic [AXIL_DATA_WIDTH-1:0]   s_axil_wdata;
    logic [AXIL_STRB_WIDTH-1:0]   s_axil_wstrb;
    logic                         s_axil_wvalid;
    logic                         s_axil_wready;
    logic [1:0]                   s_axil_bresp;
    logic                         s_axil_bvalid;
    logic                         s_axil_bready;
    logic [AXIL_ADDR_WIDTH-1:0]   s_axil_araddr;
    logic                         s_axil_arvalid;
    logic                         s_axil_arready;
    logic [AXIL_DATA_WIDTH-1:0]   s_axil_rdata;
    logic [1:0]                   s_axil_rresp;
    logic                         s_axil_rvalid;
    logic                         s_axil_rready;
    logic [31:0]                  s_tdata;
    logic [DEST_WIDTH-1:0]        s_tdest;
    logic                         s_tlast;
    logic                         s_tvalid;
    logic                         s_tready;
    logic [ADDR_WIDTH-1:0]        m_axi_awaddr;
    logic [7:0]                   m_axi_awlen;
    logic [2:0]                   m_axi_awsize;
    logic                         m_axi_awvalid;
    logic                         m_axi_awready;
    logic [BEAT_WIDTH-1:0]        m_axi_wdata;
    logic [BEAT_BYTES-1:0]        m_axi_wstrb;
    logic                         m_axi_wlast;
    logic                         m_axi_wvalid;
    logic                         m_axi_wready;
    logic [1:0]                   m_axi_bresp;
    logic                         m_axi_bvalid;
    logic                         m_axi_bready;

    // Byte-addressed memory behind the write master
    logic [7:0]  mem [logic [31:0]];
    logic [31:0] rng_state = 32'h3435;
    logic [31:0] sample_data [64];
    logic [11:0] sample_dest [64];
    int          write_count = 0;
    int          b_count     = 0;
    int          row_beats   = 0;
    logic        row_active  = 1'b0;

    stream_dma #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DEST_WIDTH(DEST_WIDTH)
    ) u_stream_dma (.*);

    initial begin
        axi_out = 1'b0;
        forever #50 axi_out = ~axi_out;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [7:0] read_byte(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return 8'hxx;
    endfunction

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic random_wait();
        int delay;
        delay = int'(next_random() % 4);
        repeat (delay) @(negedge axi_out);
    endtask

    // AW and W are offered together, the handshake is seen at the rising edge
    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        s_axil_awaddr  = addr;
        s_axil_awvalid = 1'b1;
        s_axil_wdata   = data;
        s_axil_wstrb   = 4'hF;
        s_axil_wvalid  = 1'b1;
        s_axil_bready  = 1'b1;
        @(posedge axi_out);
        while (!(s_axil_awready && s_axil_wready)) @(posedge axi_out);
        @(negedge axi_out);
        check_value("s_axil_bvalid", s_axil_bvalid, 1'b1);
        check_value("s_axil_bresp", s_axil_bresp, 2'b00);
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        @(negedge axi_out);
        s_axil_bready = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        s_axil_rready  = 1'b1;
        @(posedge axi_out);
        while (!s_axil_arready) @(posedge axi_out);
        @(negedge axi_out);
        check_value("s_axil_rvalid", s_axil_rvalid, 1'b1);
        check_value("s_axil_rresp", s_axil_rresp, 2'b00);
        s_axil_arvalid = 1'b0;
        data = s_axil_rdata;
        @(negedge axi_out);
        s_axil_rready = 1'b0;
    endtask

    task automatic send_samples(input int count);
        for (int i = 0; i < count; i++) begin
            s_tdata  = sample_data[i];
            s_tdest  = sample_dest[i];
            s_tlast  = (i == count - 1);
            s_tvalid = 1'b1;
            while (!s_tready) @(negedge axi_out);
            @(negedge axi_out);
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    // With no transfer armed the stream must stay stalled
    task automatic check_stream_closed();
        s_tdata  = 32'hDEAD_BEEF;
        s_tdest  = '0;
        s_tlast  = 1'b0;
        s_tvalid = 1'b1;
        repeat (20) begin
            @(negedge axi_out);
            check_value("s_tready", s_tready, 1'b0);
        end
        s_tvalid = 1'b0;
    endtask

    task automatic check_memory(input logic [31:0] base, input int count);
        logic [127:0] got;
        logic [127:0] exp;
        logic [31:0]  addr;
        for (int k = 0; k < (count + 1) / 2; k++) begin
            addr = base + 32'(16 * k);
            for (int b = 0; b < 16; b++) begin
                got[8*b +: 8] = read_byte(addr + 32'(b));
            end
            exp = '0;
            exp[31:0]  = sample_data[2*k];
            exp[63:32] = 32'(sample_dest[2*k]);
            if (2 * k + 1 < count) begin
                exp[95:64]  = sample_data[2*k+1];
                exp[127:96] = 32'(sample_dest[2*k+1]);
                check_value($sformatf("mem[0x%0h]", addr), got, exp);
            end else begin
                // A lone final sample fills only the low half
                check_value($sformatf("mem[0x%0h] low half", addr), got[63:0], exp[63:0]);
                check_value("final beat upper half", got[127:64], '0);
            end
        end
    endtask

    task automatic run_row(input logic [31:0] base, input int count);
        logic [31:0] value;
        int          beats;
        beats       = (count + 1) / 2;
        row_beats   = beats;
        write_count = 0;
        b_count     = 0;
        for (int i = 0; i < count; i++) begin
            sample_data[i] = next_random();
            sample_dest[i] = 12'(i + 1000);
        end
        write_reg(REG_BASE, base);
        read_reg(REG_BASE, value);
        check_value("BASE", value, base);
        write_reg(REG_CTRL, 32'h1);
        row_active = 1'b1;
        read_reg(REG_CTRL, value);
        check_value("CTRL", value, '0);
        // Busy set, done clear
        read_reg(REG_STATUS, value);
        check_value("STATUS after arm", value, 32'h2);
        send_samples(count);
        do begin
            read_reg(REG_STATUS, value);
        end while (!value[STATUS_DONE_BIT]);
        check_value("STATUS at done", value, 32'h1);
        read_reg(REG_COUNT, value);
        check_value("COUNT", value, beats);
        check_value("write handshakes", write_count, beats);
        check_memory(base, count);
        row_active = 1'b0;
        check_stream_closed();
    endtask

    // Slave side of the write bus with random stalls on every channel
    initial begin : memory_model
        logic [31:0]           addr;
        logic [BEAT_WIDTH-1:0] data;
        logic [BEAT_BYTES-1:0] strb;
        m_axi_awready = 1'b0;
        m_axi_wready  = 1'b0;
        m_axi_bvalid  = 1'b0;
        m_axi_bresp   = 2'b00;
        forever begin
            @(negedge axi_out);
            if (m_axi_awvalid) begin
                random_wait();
                addr = m_axi_awaddr;
                check_value("m_axi_awlen", m_axi_awlen, 8'd0);
                check_value("m_axi_awsize", m_axi_awsize, 3'd4);
                m_axi_awready = 1'b1;
                @(negedge axi_out);
                m_axi_awready = 1'b0;
                while (!m_axi_wvalid) @(negedge axi_out);
                random_wait();
                data = m_axi_wdata;
                strb = m_axi_wstrb;
                check_value("m_axi_wlast", m_axi_wlast, 1'b1);
                check_value("m_axi_wstrb", strb, 16'hFFFF);
                m_axi_wready = 1'b1;
                @(negedge axi_out);
                m_axi_wready = 1'b0;
                write_count++;
                for (int b = 0; b < BEAT_BYTES; b++) begin
                    if (strb[b]) begin
                        mem[addr + 32'(b)] = data[8*b +: 8];
                    end
                end
                while (!m_axi_bready) @(negedge axi_out);
                random_wait();
                // bready is already high, so the response is taken at the next edge
                m_axi_bvalid = 1'b1;
                b_count++;
                @(negedge axi_out);
                m_axi_bvalid = 1'b0;
            end
        end
    end

    // done must not appear while responses are still outstanding
    initial begin : done_monitor
        forever begin
            @(negedge axi_out);
            if (row_active && u_stream_dma.done) begin
                check_value("B responses at done", b_count, row_beats);
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += ROW_COUNT[r] * 20 + 200;
        end
        repeat (limit) @(posedge axi_out);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        logic [31:0] value;
        rst            = 1'b1;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        s_tdata        = '0;
        s_tdest        = '0;
        s_tlast        = 1'b0;
        s_tvalid       = 1'b0;
        repeat (4) @(posedge axi_out);
        @(negedge axi_out);
        rst = 1'b0;

        read_reg(REG_BASE, value);
        check_value("BASE after reset", value, '0);
        read_reg(REG_COUNT, value);
        check_value("COUNT after reset", value, '0);
        read_reg(REG_STATUS, value);
        check_value("STATUS after reset", value, '0);
        check_stream_closed();

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(ROW_BASE[r], ROW_COUNT[r]);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- all.f
rtl/dma_reg_pkg.sv
rtl/dma_data_pkg.sv
rtl/beat_if.sv
rtl/dma_regs.sv
rtl/sample_packer.sv
rtl/axi_write_master.sv
rtl/stream_dma.sv
verification/stream_dma_tb.sv

//--- Makefile
# Verilator simulation of the stream DMA testbench

TOP             ?= stream_dma_tb
FILELIST        ?= all.f
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --assert -Wno-fatal

.PHONY: sim clean

# The run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
